//--- include/tomasulo_params.svh
`ifndef TOMASULO_PARAMS_SVH
`define TOMASULO_PARAMS_SVH

// structure sizes
`define ROB_DEPTH 8
`define RS_DEPTH 3

// execution latencies, dispatch edge to result
`define ADD_LATENCY 2
`define MUL_LATENCY 3

// opcodes
`define OP_ADD 2'd0
`define OP_SUB 2'd1
`define OP_MUL 2'd2

`endif

//--- verilog/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    typedef logic [7:0] data_t;    // operand and result
    typedef logic [3:0] reg_idx_t; // architectural register
    typedef logic [2:0] rob_tag_t; // rob slot, also the bus tag
    typedef logic [1:0] op_t;

    // shared by both execution units
    typedef enum logic [1:0] {
        UNIT_IDLE,
        UNIT_BUSY,
        UNIT_DONE
    } unit_state_t;

endpackage

`default_nettype wire

//--- verilog/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_params.svh"

module reservation_station (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         alloc,
    input  wire tomasulo_pkg::op_t      alloc_op,
    input  wire tomasulo_pkg::rob_tag_t alloc_tag,
    input  wire                         src1_busy,
    input  wire tomasulo_pkg::rob_tag_t src1_tag,
    input  wire tomasulo_pkg::data_t    src1_value,
    input  wire                         src1_rob_ready,
    input  wire tomasulo_pkg::data_t    src1_rob_value,
    input  wire                         src2_busy,
    input  wire tomasulo_pkg::rob_tag_t src2_tag,
    input  wire tomasulo_pkg::data_t    src2_value,
    input  wire                         src2_rob_ready,
    input  wire tomasulo_pkg::data_t    src2_rob_value,
    input  wire                         cdb_valid,
    input  wire tomasulo_pkg::rob_tag_t cdb_tag,
    input  wire tomasulo_pkg::data_t    cdb_value,
    input  wire                         unit_busy,
    output logic                        full,
    output logic                        start,
    output tomasulo_pkg::op_t           start_op,
    output tomasulo_pkg::data_t         start_a,
    output tomasulo_pkg::data_t         start_b,
    output tomasulo_pkg::rob_tag_t      start_tag
);

    typedef logic [$clog2(`RS_DEPTH)-1:0] slot_t;

    logic                   valid  [`RS_DEPTH];
    tomasulo_pkg::op_t      op     [`RS_DEPTH];
    tomasulo_pkg::data_t    val_a  [`RS_DEPTH];
    tomasulo_pkg::data_t    val_b  [`RS_DEPTH];
    tomasulo_pkg::rob_tag_t tag_a  [`RS_DEPTH];
    tomasulo_pkg::rob_tag_t tag_b  [`RS_DEPTH];
    logic                   wait_a [`RS_DEPTH];
    logic                   wait_b [`RS_DEPTH];
    tomasulo_pkg::rob_tag_t dest   [`RS_DEPTH];

    slot_t               free_idx;
    slot_t               ready_idx;
    logic                free_found;
    logic                ready_found;
    logic                src1_ready;
    logic                src2_ready;
    tomasulo_pkg::data_t src1_pick;
    tomasulo_pkg::data_t src2_pick;

    // descending scan leaves the lowest index
    always_comb
    begin
        free_found  = 1'b0;
        free_idx    = '0;
        ready_found = 1'b0;
        ready_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--)
        begin
            if (!valid[i])
            begin
                free_found = 1'b1;
                free_idx   = slot_t'(i);
            end
            if (valid[i] && !wait_a[i] && !wait_b[i])
            begin
                ready_found = 1'b1;
                ready_idx   = slot_t'(i);
            end
        end
    end

    // operand state decided once, at allocation
    assign src1_ready = !src1_busy || src1_rob_ready || (cdb_valid && cdb_tag == src1_tag);
    assign src2_ready = !src2_busy || src2_rob_ready || (cdb_valid && cdb_tag == src2_tag);
    assign src1_pick  = !src1_busy ? src1_value : (src1_rob_ready ? src1_rob_value : cdb_value);
    assign src2_pick  = !src2_busy ? src2_value : (src2_rob_ready ? src2_rob_value : cdb_value);

    assign full      = !free_found;
    assign start     = ready_found && !unit_busy;
    assign start_op  = op[ready_idx];
    assign start_a   = val_a[ready_idx];
    assign start_b   = val_b[ready_idx];
    assign start_tag = dest[ready_idx];

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RS_DEPTH; i++)
                valid[i] <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < `RS_DEPTH; i++)
            begin
                if (valid[i] && cdb_valid && wait_a[i] && tag_a[i] == cdb_tag)
                begin
                    val_a[i]  <= cdb_value;
                    wait_a[i] <= 1'b0;
                end
                if (valid[i] && cdb_valid && wait_b[i] && tag_b[i] == cdb_tag)
                begin
                    val_b[i]  <= cdb_value;
                    wait_b[i] <= 1'b0;
                end
            end
            if (start)
                valid[ready_idx] <= 1'b0;
            if (alloc && free_found)
            begin
                valid[free_idx]  <= 1'b1;
                op[free_idx]     <= alloc_op;
                dest[free_idx]   <= alloc_tag;
                val_a[free_idx]  <= src1_pick;
                tag_a[free_idx]  <= src1_tag;
                wait_a[free_idx] <= !src1_ready;
                val_b[free_idx]  <= src2_pick;
                tag_b[free_idx]  <= src2_tag;
                wait_b[free_idx] <= !src2_ready;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/add_sub_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_params.svh"

module add_sub_unit (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         start,
    input  wire tomasulo_pkg::op_t      start_op,
    input  wire tomasulo_pkg::data_t    start_a,
    input  wire tomasulo_pkg::data_t    start_b,
    input  wire tomasulo_pkg::rob_tag_t start_tag,
    input  wire                         cdb_blocked,
    output logic                        busy,
    output logic                        result_valid,
    output tomasulo_pkg::rob_tag_t      result_tag,
    output tomasulo_pkg::data_t         result_value
);

    localparam logic [1:0] last_count = 2'(`ADD_LATENCY - 1);

    tomasulo_pkg::unit_state_t state;
    logic [1:0]                count;

    assign busy         = state != tomasulo_pkg::UNIT_IDLE;
    assign result_valid = state == tomasulo_pkg::UNIT_DONE;

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            state <= tomasulo_pkg::UNIT_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                tomasulo_pkg::UNIT_IDLE:
                begin
                    if (start)
                    begin
                        state        <= tomasulo_pkg::UNIT_BUSY;
                        count        <= '0;
                        result_tag   <= start_tag;
                        // wraps mod 256
                        result_value <= (start_op == `OP_SUB) ? start_a - start_b
                                                              : start_a + start_b;
                    end
                end
                tomasulo_pkg::UNIT_BUSY:
                begin
                    if (count == last_count)
                        state <= tomasulo_pkg::UNIT_DONE;
                    else
                        count <= count + 2'd1;
                end
                default:
                begin
                    if (!cdb_blocked) // mul owns the bus otherwise
                        state <= tomasulo_pkg::UNIT_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_params.svh"

module mul_unit (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         start,
    input  wire tomasulo_pkg::data_t    start_a,
    input  wire tomasulo_pkg::data_t    start_b,
    input  wire tomasulo_pkg::rob_tag_t start_tag,
    output logic                        busy,
    output logic                        result_valid,
    output tomasulo_pkg::rob_tag_t      result_tag,
    output tomasulo_pkg::data_t         result_value
);

    localparam logic [1:0] last_count = 2'(`MUL_LATENCY - 1);

    tomasulo_pkg::unit_state_t state;
    logic [1:0]                count;

    assign busy         = state != tomasulo_pkg::UNIT_IDLE;
    assign result_valid = state == tomasulo_pkg::UNIT_DONE;

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            state <= tomasulo_pkg::UNIT_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                tomasulo_pkg::UNIT_IDLE:
                begin
                    if (start)
                    begin
                        state        <= tomasulo_pkg::UNIT_BUSY;
                        count        <= '0;
                        result_tag   <= start_tag;
                        result_value <= start_a * start_b; // low byte only
                    end
                end
                tomasulo_pkg::UNIT_BUSY:
                begin
                    if (count == last_count)
                        state <= tomasulo_pkg::UNIT_DONE;
                    else
                        count <= count + 2'd1;
                end
                default:
                    state <= tomasulo_pkg::UNIT_IDLE; // bus always taken
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_params.svh"

module reorder_buffer (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         issue_valid,
    input  wire tomasulo_pkg::op_t      issue_op,
    input  wire tomasulo_pkg::reg_idx_t issue_rd,
    input  wire                         add_rs_full,
    input  wire                         mul_rs_full,
    input  wire tomasulo_pkg::rob_tag_t src1_tag,
    input  wire tomasulo_pkg::rob_tag_t src2_tag,
    input  wire                         add_valid,
    input  wire tomasulo_pkg::rob_tag_t add_tag,
    input  wire tomasulo_pkg::data_t    add_value,
    input  wire                         mul_valid,
    input  wire tomasulo_pkg::rob_tag_t mul_tag,
    input  wire tomasulo_pkg::data_t    mul_value,
    output logic                        issue_full,
    output logic                        add_alloc,
    output logic                        mul_alloc,
    output tomasulo_pkg::rob_tag_t      alloc_tag,
    output logic                        src1_rob_ready,
    output tomasulo_pkg::data_t         src1_rob_value,
    output logic                        src2_rob_ready,
    output tomasulo_pkg::data_t         src2_rob_value,
    output logic                        cdb_valid,
    output tomasulo_pkg::rob_tag_t      cdb_tag,
    output tomasulo_pkg::data_t         cdb_value,
    output logic                        commit_valid,
    output tomasulo_pkg::reg_idx_t      commit_rd,
    output tomasulo_pkg::data_t         commit_value,
    output tomasulo_pkg::rob_tag_t      commit_tag
);

    logic [$clog2(`ROB_DEPTH+1)-1:0] count;
    tomasulo_pkg::rob_tag_t          head;
    tomasulo_pkg::rob_tag_t          tail;
    logic                            accept;
    logic                            is_mul;

    logic                   done  [`ROB_DEPTH];
    tomasulo_pkg::reg_idx_t rd    [`ROB_DEPTH];
    tomasulo_pkg::data_t    value [`ROB_DEPTH];

    // full if rob or the targeted station has no room
    assign is_mul     = issue_op == `OP_MUL;
    assign issue_full = (count == `ROB_DEPTH) || (is_mul ? mul_rs_full : add_rs_full);
    assign accept     = issue_valid && !issue_full;
    assign add_alloc  = accept && !is_mul;
    assign mul_alloc  = accept && is_mul;
    assign alloc_tag  = tail;

    assign src1_rob_ready = done[src1_tag];
    assign src1_rob_value = value[src1_tag];
    assign src2_rob_ready = done[src2_tag];
    assign src2_rob_value = value[src2_tag];

    // mul wins the bus
    assign cdb_valid = mul_valid || add_valid;
    assign cdb_tag   = mul_valid ? mul_tag : add_tag;
    assign cdb_value = mul_valid ? mul_value : add_value;

    assign commit_valid = done[head];
    assign commit_rd    = rd[head];
    assign commit_value = value[head];
    assign commit_tag   = head;

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++)
                done[i] <= 1'b0;
        end
        else
        begin
            if (cdb_valid)
            begin
                done[cdb_tag]  <= 1'b1;
                value[cdb_tag] <= cdb_value;
            end
            if (commit_valid)
            begin
                done[head] <= 1'b0;
                head       <= head + 3'd1;
            end
            if (accept)
            begin
                rd[tail] <= issue_rd;
                tail     <= tail + 3'd1; // depth is a power of two
            end
            count <= count + {3'd0, accept} - {3'd0, commit_valid};
        end
    end

endmodule

`default_nettype wire

//--- verilog/register_status.sv
`timescale 1ns/1ns
`default_nettype none

module register_status (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         alloc_any,
    input  wire tomasulo_pkg::reg_idx_t alloc_rd,
    input  wire tomasulo_pkg::rob_tag_t alloc_tag,
    input  wire tomasulo_pkg::reg_idx_t issue_rs1,
    input  wire tomasulo_pkg::reg_idx_t issue_rs2,
    input  wire                         commit_valid,
    input  wire tomasulo_pkg::reg_idx_t commit_rd,
    input  wire tomasulo_pkg::data_t    commit_value,
    input  wire tomasulo_pkg::rob_tag_t commit_tag,
    output logic                        src1_busy,
    output tomasulo_pkg::rob_tag_t      src1_tag,
    output tomasulo_pkg::data_t         src1_value,
    output logic                        src2_busy,
    output tomasulo_pkg::rob_tag_t      src2_tag,
    output tomasulo_pkg::data_t         src2_value
);

    localparam int num_regs = 16;

    tomasulo_pkg::data_t    regs [num_regs];
    logic                   busy [num_regs];
    tomasulo_pkg::rob_tag_t tag  [num_regs];

    // a same-cycle commit from the recorded producer frees the source
    assign src1_busy  = busy[issue_rs1]
                        && !(commit_valid && commit_rd == issue_rs1 && tag[issue_rs1] == commit_tag);
    assign src2_busy  = busy[issue_rs2]
                        && !(commit_valid && commit_rd == issue_rs2 && tag[issue_rs2] == commit_tag);
    assign src1_tag   = tag[issue_rs1];
    assign src2_tag   = tag[issue_rs2];
    assign src1_value = (commit_valid && commit_rd == issue_rs1) ? commit_value : regs[issue_rs1];
    assign src2_value = (commit_valid && commit_rd == issue_rs2) ? commit_value : regs[issue_rs2];

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= tomasulo_pkg::data_t'(i); // r holds r
                busy[i] <= 1'b0;
                tag[i]  <= '0;
            end
        end
        else
        begin
            if (commit_valid)
            begin
                regs[commit_rd] <= commit_value;
                if (tag[commit_rd] == commit_tag)
                    busy[commit_rd] <= 1'b0;
            end
            // newer producer overrides the commit clear
            if (alloc_any)
            begin
                busy[alloc_rd] <= 1'b1;
                tag[alloc_rd]  <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/tomasulo_core.sv
`timescale 1ns/1ns
`default_nettype none

module tomasulo_core (
    input  wire                         clk1,
    input  wire                         rst,
    input  wire                         issue_valid,
    input  wire tomasulo_pkg::op_t      issue_op,
    input  wire tomasulo_pkg::reg_idx_t issue_rd,
    input  wire tomasulo_pkg::reg_idx_t issue_rs1,
    input  wire tomasulo_pkg::reg_idx_t issue_rs2,
    output logic                        issue_full,
    output logic                        commit_valid,
    output tomasulo_pkg::reg_idx_t      commit_rd,
    output tomasulo_pkg::data_t         commit_value
);

    logic                   add_alloc, mul_alloc, add_rs_full, mul_rs_full;
    tomasulo_pkg::rob_tag_t alloc_tag, commit_tag;
    logic                   src1_busy, src2_busy, src1_rob_ready, src2_rob_ready;
    tomasulo_pkg::rob_tag_t src1_tag, src2_tag;
    tomasulo_pkg::data_t    src1_value, src2_value, src1_rob_value, src2_rob_value;
    logic                   cdb_valid;
    tomasulo_pkg::rob_tag_t cdb_tag;
    tomasulo_pkg::data_t    cdb_value;

    // station to unit
    logic                   add_start, mul_start, add_busy, mul_busy;
    tomasulo_pkg::op_t      add_start_op;
    tomasulo_pkg::data_t    add_start_a, add_start_b, mul_start_a, mul_start_b;
    tomasulo_pkg::rob_tag_t add_start_tag, mul_start_tag;

    // unit results
    logic                   add_result_valid, mul_result_valid;
    tomasulo_pkg::rob_tag_t add_result_tag, mul_result_tag;
    tomasulo_pkg::data_t    add_result_value, mul_result_value;

    reservation_station add_rs (
        .clk1(clk1), .rst(rst), .alloc(add_alloc), .alloc_op(issue_op), .alloc_tag(alloc_tag),
        .src1_busy(src1_busy), .src1_tag(src1_tag), .src1_value(src1_value),
        .src1_rob_ready(src1_rob_ready), .src1_rob_value(src1_rob_value),
        .src2_busy(src2_busy), .src2_tag(src2_tag), .src2_value(src2_value),
        .src2_rob_ready(src2_rob_ready), .src2_rob_value(src2_rob_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .unit_busy(add_busy), .full(add_rs_full), .start(add_start), .start_op(add_start_op),
        .start_a(add_start_a), .start_b(add_start_b), .start_tag(add_start_tag)
    );

    reservation_station mul_rs (
        .clk1(clk1), .rst(rst), .alloc(mul_alloc), .alloc_op(issue_op), .alloc_tag(alloc_tag),
        .src1_busy(src1_busy), .src1_tag(src1_tag), .src1_value(src1_value),
        .src1_rob_ready(src1_rob_ready), .src1_rob_value(src1_rob_value),
        .src2_busy(src2_busy), .src2_tag(src2_tag), .src2_value(src2_value),
        .src2_rob_ready(src2_rob_ready), .src2_rob_value(src2_rob_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .unit_busy(mul_busy), .full(mul_rs_full), .start(mul_start), .start_op(),
        .start_a(mul_start_a), .start_b(mul_start_b), .start_tag(mul_start_tag)
    );

    add_sub_unit i_add_sub_unit (
        .clk1(clk1), .rst(rst), .start(add_start), .start_op(add_start_op),
        .start_a(add_start_a), .start_b(add_start_b), .start_tag(add_start_tag),
        .cdb_blocked(mul_result_valid), .busy(add_busy), .result_valid(add_result_valid),
        .result_tag(add_result_tag), .result_value(add_result_value)
    );

    mul_unit i_mul_unit (
        .clk1(clk1), .rst(rst), .start(mul_start), .start_a(mul_start_a),
        .start_b(mul_start_b), .start_tag(mul_start_tag), .busy(mul_busy),
        .result_valid(mul_result_valid), .result_tag(mul_result_tag),
        .result_value(mul_result_value)
    );

    reorder_buffer i_reorder_buffer (
        .clk1(clk1), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .add_rs_full(add_rs_full), .mul_rs_full(mul_rs_full),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .add_valid(add_result_valid), .add_tag(add_result_tag), .add_value(add_result_value),
        .mul_valid(mul_result_valid), .mul_tag(mul_result_tag), .mul_value(mul_result_value),
        .issue_full(issue_full), .add_alloc(add_alloc), .mul_alloc(mul_alloc),
        .alloc_tag(alloc_tag), .src1_rob_ready(src1_rob_ready),
        .src1_rob_value(src1_rob_value), .src2_rob_ready(src2_rob_ready),
        .src2_rob_value(src2_rob_value), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_value(commit_value), .commit_tag(commit_tag)
    );

    register_status i_register_status (
        .clk1(clk1), .rst(rst), .alloc_any(add_alloc || mul_alloc), .alloc_rd(issue_rd),
        .alloc_tag(alloc_tag), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .commit_tag(commit_tag), .src1_busy(src1_busy), .src1_tag(src1_tag),
        .src1_value(src1_value), .src2_busy(src2_busy), .src2_tag(src2_tag),
        .src2_value(src2_value)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk1,
    output logic rst
);

    initial
    begin
        clk1 = 1'b0;
        forever #10 clk1 = ~clk1; // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk1);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tomasulo_sva.sv
`timescale 1ns/1ns
`default_nettype none

module tomasulo_sva (
    input wire                         clk1,
    input wire                         rst,
    input wire                         issue_full,
    input wire                         add_alloc,
    input wire                         mul_alloc,
    input wire                         commit_valid,
    input wire                         add_result_valid,
    input wire                         mul_result_valid,
    input wire tomasulo_pkg::rob_tag_t add_result_tag,
    input wire tomasulo_pkg::data_t    add_result_value
);

    // single issue, so one station at most
    single_alloc: assert property (@(posedge clk1) disable iff (rst)
        !(add_alloc && mul_alloc))
        else $error("add and mul stations allocated in the same cycle");

    no_alloc_when_full: assert property (@(posedge clk1) disable iff (rst)
        (add_alloc || mul_alloc) |-> !issue_full)
        else $error("station allocated while issue_full was high");

    quiet_in_reset: assert property (@(posedge clk1)
        rst && $past(rst) |-> !commit_valid)
        else $error("commit_valid high during reset");

    // mul owns the bus, add result must hold
    blocked_add_holds: assert property (@(posedge clk1) disable iff (rst)
        add_result_valid && mul_result_valid |=>
            add_result_valid && $stable(add_result_tag) && $stable(add_result_value))
        else $error("blocked add result changed before the bus took it");

endmodule

`default_nettype wire

//--- dv/tomasulo_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_params.svh"

module tomasulo_tb;

    logic                   clk1;
    logic                   rst;
    logic                   issue_valid;
    tomasulo_pkg::op_t      issue_op;
    tomasulo_pkg::reg_idx_t issue_rd;
    tomasulo_pkg::reg_idx_t issue_rs1;
    tomasulo_pkg::reg_idx_t issue_rs2;
    logic                   issue_full;
    logic                   commit_valid;
    tomasulo_pkg::reg_idx_t commit_rd;
    tomasulo_pkg::data_t    commit_value;

    tomasulo_pkg::data_t    model_regs [16];
    tomasulo_pkg::reg_idx_t exp_rd [$];    // expected commits, program order
    tomasulo_pkg::data_t    exp_value [$];
    integer                 seed;
    logic [31:0]            rnd;
    int                     waited;

    tb_clock i_tb_clock (.clk1(clk1), .rst(rst));

    tomasulo_core i_tomasulo_core (
        .clk1(clk1), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_full(issue_full), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_value(commit_value)
    );

    bind tomasulo_core tomasulo_sva i_tomasulo_sva (
        .clk1(clk1), .rst(rst), .issue_full(issue_full), .add_alloc(add_alloc),
        .mul_alloc(mul_alloc), .commit_valid(commit_valid),
        .add_result_valid(add_result_valid), .mul_result_valid(mul_result_valid),
        .add_result_tag(add_result_tag), .add_result_value(add_result_value)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // in-order reference, results modulo 256
    task automatic model_issue(input tomasulo_pkg::op_t op, input tomasulo_pkg::reg_idx_t rd,
                               input tomasulo_pkg::reg_idx_t rs1,
                               input tomasulo_pkg::reg_idx_t rs2);
        int a;
        int b;
        int res;
        a = int'(model_regs[rs1]);
        b = int'(model_regs[rs2]);
        if (op == `OP_MUL)
            res = (a * b) % 256;
        else if (op == `OP_SUB)
            res = (a - b + 256) % 256;
        else
            res = (a + b) % 256;
        model_regs[rd] = tomasulo_pkg::data_t'(res);
        exp_rd.push_back(rd);
        exp_value.push_back(tomasulo_pkg::data_t'(res));
    endtask

    // called at edge+2, returns at edge+2 after the accepting edge
    task automatic issue_instr(input tomasulo_pkg::op_t op, input tomasulo_pkg::reg_idx_t rd,
                               input tomasulo_pkg::reg_idx_t rs1,
                               input tomasulo_pkg::reg_idx_t rs2);
        int   tries;
        logic accepted;
        tries       = 0;
        accepted    = 1'b0;
        issue_op    = op;
        issue_rd    = rd;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_valid = 1'b1;
        while (!accepted)
        begin
            @(negedge clk1);
            accepted = !issue_full;
            @(posedge clk1);
            #2;
            tries++;
            if (tries >= 200)
                abort_run("timeout waiting for issue_full to drop");
        end
        issue_valid = 1'b0;
        model_issue(op, rd, rs1, rs2);
    endtask

    task automatic wait_drain(input string phase);
        int cycles;
        cycles = 0;
        while (exp_rd.size() != 0)
        begin
            @(posedge clk1);
            #2;
            cycles++;
            if (cycles >= 200)
                abort_run({"timeout waiting for the ", phase, " commits"});
        end
    endtask

    always @(negedge clk1)
    begin
        if (!rst && commit_valid)
        begin
            assert (exp_rd.size() != 0)
            else abort_run("a commit arrived with no instruction outstanding");
            if (exp_rd.size() != 0)
            begin
                assert (commit_rd == exp_rd[0])
                else abort_run($sformatf("[ERROR] %0t: commit_rd %0d, expected %0d",
                                         $time, commit_rd, exp_rd[0]));
                assert (commit_value == exp_value[0])
                else abort_run($sformatf("[ERROR] %0t: commit_value %0d for r%0d, expected %0d",
                                         $time, commit_value, commit_rd, exp_value[0]));
                void'(exp_rd.pop_front());
                void'(exp_value.pop_front());
            end
        end
    end

    initial
    begin
        issue_valid = 1'b0;
        issue_op    = `OP_ADD;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        seed        = 68821;
        waited      = 0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = tomasulo_pkg::data_t'(i);

        @(posedge clk1);
        while (rst)
        begin
            @(posedge clk1);
            waited++;
            if (waited >= 200)
                abort_run("timeout waiting for reset to be released");
        end
        #2;
        assert (!commit_valid && !issue_full)
        else abort_run($sformatf("[ERROR] %0t: commit_valid or issue_full high after reset",
                                 $time));

        issue_instr(`OP_ADD, 4'd3, 4'd1, 4'd2); // r3 = 3
        wait_drain("first add");

        issue_instr(`OP_SUB, 4'd4, 4'd0, 4'd1); // 0 - 1 wraps to 255
        issue_instr(`OP_ADD, 4'd5, 4'd4, 4'd4); // 255 + 255 wraps
        wait_drain("wrap");

        issue_instr(`OP_ADD, 4'd6, 4'd10, 4'd10);
        issue_instr(`OP_MUL, 4'd7, 4'd6, 4'd6); // 20 * 20, low byte 144
        wait_drain("multiply");

        // each one reads the previous destination
        issue_instr(`OP_ADD, 4'd8, 4'd3, 4'd1);
        issue_instr(`OP_SUB, 4'd9, 4'd8, 4'd2);
        issue_instr(`OP_MUL, 4'd10, 4'd9, 4'd9);
        issue_instr(`OP_ADD, 4'd11, 4'd10, 4'd8);
        issue_instr(`OP_SUB, 4'd8, 4'd11, 4'd10);
        wait_drain("dependent chain");

        // mul then add back to back, both results land in the same cycle
        issue_instr(`OP_MUL, 4'd12, 4'd13, 4'd14);
        issue_instr(`OP_ADD, 4'd13, 4'd14, 4'd15);
        wait_drain("bus contention");

        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            issue_instr(tomasulo_pkg::op_t'(rnd[1:0] % 2'd3), {2'b00, rnd[5:4]},
                        rnd[11:8], rnd[15:12]);
        end
        wait_drain("random flood");

        repeat (5) @(posedge clk1); // idle window, catches stray commits
        if (exp_rd.size() == 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
            abort_run("expected commits still outstanding at the end");
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/tomasulo_pkg.sv
verilog/reservation_station.sv
verilog/add_sub_unit.sv
verilog/mul_unit.sv
verilog/reorder_buffer.sv
verilog/register_status.sv
verilog/tomasulo_core.sv
dv/tb_clock.sv
dv/tomasulo_sva.sv
dv/tomasulo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tomasulo_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtomasulo_tb 2>&1 | tee /dev/stderr | grep "TB PASSED" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
